/* source/cw_route_pkg.sv */
package cw_route_pkg;

	typedef logic [5:0]  reg_addr_t;   // host register address
	typedef logic [7:0]  reg_byte_t;   // one register data byte
	typedef logic [15:0] bytecnt_t;    // byte index in a multi-byte register
	typedef logic [15:0] hyplen_t;     // register length in bytes

	localparam reg_addr_t CW_TRIGSRC_ADDR = 6'd39;
	localparam reg_addr_t CW_TRIGMOD_ADDR = 6'd40;
	localparam reg_addr_t CW_IOROUTE_ADDR = 6'd55;
	localparam int        IOROUTE_BYTES   = 8;

	localparam reg_byte_t                  TRIGSRC_RESET = 8'h01;   // front panel A only
	localparam reg_byte_t                  TRIGMOD_RESET = 8'h00;
	localparam logic [IOROUTE_BYTES*8-1:0] IOROUTE_RESET = 64'h0201; // gpio1 tx, gpio2 rx

	typedef enum logic [1:0] {
		COMB_OR   = 2'd0,
		COMB_AND  = 2'd1,
		COMB_NAND = 2'd2,
		COMB_OFF  = 2'd3   // combined trigger held low
	} trig_combine_e;

	typedef enum logic [2:0] {
		MOD_EXT        = 3'd0,   // combined external trigger
		MOD_ADVIO      = 3'd1,
		MOD_ANAPATTERN = 3'd2,
		MOD_DECODEDIO  = 3'd3,
		MOD_MMC        = 3'd4,
		MOD_EDGE       = 3'd5
	} trig_module_e;

	typedef enum logic [1:0] {
		PWR_ON   = 2'd0,
		PWR_OFF  = 2'd1,
		PWR_SOFT = 2'd2    // pwm soft-start in progress
	} power_state_e;

	typedef struct packed {
		reg_addr_t addr;
		bytecnt_t  bytecnt;
		reg_byte_t wdata;
		logic      read;
		logic      write;
		logic      addrvalid;   // qualifies addr for the read path
	} reg_bus_t;

	typedef struct packed {
		trig_combine_e mode;      // bits 7:6
		logic [5:0]    enable;    // bit 0 fa, bit 1 fb, bits 5:2 io1..io4
	} trig_src_cfg_t;

	typedef struct packed {
		trig_module_e secondary;  // 0 means disabled here
		logic         fpb_out;    // readback only
		logic         fpa_out;    // readback only
		trig_module_e primary;
	} trig_mod_cfg_t;

	typedef struct packed {
		logic drive;   // static drive enable
		logic level;   // static drive value
		logic txo;     // uart tx open collector, gpio3 only
		logic usoc;    // usi out open collector, gpio3 only
		logic usii;
		logic usio;
		logic rx;
		logic tx;
	} gpio_cfg_t;

	typedef struct packed {
		logic [4:0] rsvd;
		logic       fast_start;   // skip soft-start
		logic       power_off;
		logic       avrprog;
	} power_cfg_t;

	typedef struct packed {
		logic [1:0] rsvd;
		logic       pdic;
		logic       pdic_en;
		logic       pdid;
		logic       pdid_en;
		logic       nrst;
		logic       nrst_en;
	} pin_ctl_t;

	typedef struct packed {
		reg_byte_t  rsvd;      // byte 7
		pin_ctl_t   pin_ctl;   // byte 6
		power_cfg_t power;     // byte 5
		reg_byte_t  glitch;    // byte 4 kept for readback
		gpio_cfg_t  gpio4;
		gpio_cfg_t  gpio3;
		gpio_cfg_t  gpio2;
		gpio_cfg_t  gpio1;     // byte 0
	} io_route_cfg_t;

	typedef struct packed {
		logic advio;
		logic anapattern;
		logic decodedio;
		logic mmc;
		logic edge_trig;   // edge trigger module
	} trig_mod_in_t;

endpackage

/* source/cw_regfile.sv */
`timescale 1ns/1ps

module cw_regfile (
	input  logic                        clk,
	input  logic                        reset,
	input  cw_route_pkg::reg_bus_t      reg_bus_i,
	input  cw_route_pkg::reg_addr_t     reg_hypaddr_i,
	output cw_route_pkg::hyplen_t       reg_hyplen_o,
	output cw_route_pkg::reg_byte_t     reg_rdata_o,
	output cw_route_pkg::trig_src_cfg_t trig_src_o,
	output cw_route_pkg::trig_mod_cfg_t trig_mod_o,
	output cw_route_pkg::io_route_cfg_t io_route_o
);
	import cw_route_pkg::*;

	localparam int SEL_W = $clog2(IOROUTE_BYTES);

	trig_src_cfg_t              trigsrc_q;    // trigger source byte
	trig_mod_cfg_t              trigmod_q;    // trigger module byte
	logic [IOROUTE_BYTES*8-1:0] ioroute_q;    // routing bytes, byte 0 at the bottom
	logic [SEL_W-1:0]           byte_sel;     // routing byte picked by bytecnt
	logic [SEL_W+2:0]           bit_base;     // first bit of that byte
	logic                       addr_hit;     // addr is one of ours
	logic                       rd_valid_q;
	reg_byte_t                  rd_data_q;
	reg_byte_t                  rd_mux;

	assign byte_sel = reg_bus_i.bytecnt[SEL_W-1:0];   // upper bytecnt bits ignored
	assign bit_base = {byte_sel, 3'b000};

	always_comb begin
		case (reg_bus_i.addr)
			CW_TRIGSRC_ADDR,
			CW_TRIGMOD_ADDR,
			CW_IOROUTE_ADDR: addr_hit = 1'b1;
			default:         addr_hit = 1'b0;
		endcase
	end

	// host writes land on the edge where write is seen
	always_ff @(posedge clk) begin
		if (reset) begin
			trigsrc_q <= trig_src_cfg_t'(TRIGSRC_RESET);
			trigmod_q <= trig_mod_cfg_t'(TRIGMOD_RESET);
			ioroute_q <= IOROUTE_RESET;
		end else if (reg_bus_i.write) begin
			case (reg_bus_i.addr)
				CW_TRIGSRC_ADDR: trigsrc_q <= trig_src_cfg_t'(reg_bus_i.wdata);
				CW_TRIGMOD_ADDR: trigmod_q <= trig_mod_cfg_t'(reg_bus_i.wdata);
				CW_IOROUTE_ADDR: ioroute_q[bit_base +: 8] <= reg_bus_i.wdata;   // one byte per beat
				default: ;   // not ours
			endcase
		end
	end

	always_comb begin
		case (reg_bus_i.addr)
			CW_TRIGSRC_ADDR: rd_mux = reg_byte_t'(trigsrc_q);
			CW_TRIGMOD_ADDR: rd_mux = reg_byte_t'(trigmod_q);
			CW_IOROUTE_ADDR: rd_mux = ioroute_q[bit_base +: 8];
			default:         rd_mux = '0;
		endcase
	end

	// valid flag follows addrvalid on a known address
	always_ff @(posedge clk) begin
		if (reset)
			rd_valid_q <= 1'b0;
		else
			rd_valid_q <= reg_bus_i.addrvalid && addr_hit;
	end

	always_ff @(posedge clk) begin
		if (reg_bus_i.read)
			rd_data_q <= rd_mux;   // capture on read strobe
	end

	assign reg_rdata_o = rd_valid_q ? rd_data_q : '0;   // bus sees 0 when not ours

	// length of each register, used by the host to size transfers
	always_comb begin
		case (reg_hypaddr_i)
			CW_TRIGSRC_ADDR: reg_hyplen_o = 16'd1;
			CW_TRIGMOD_ADDR: reg_hyplen_o = 16'd1;
			CW_IOROUTE_ADDR: reg_hyplen_o = hyplen_t'(IOROUTE_BYTES);
			default:         reg_hyplen_o = '0;
		endcase
	end

	assign trig_src_o = trigsrc_q;
	assign trig_mod_o = trigmod_q;
	assign io_route_o = io_route_cfg_t'(ioroute_q);

	// host must never strobe read and write together
	a_no_rd_wr: assert property (
		@(posedge clk) disable iff (reset)
		!(reg_bus_i.read && reg_bus_i.write)
	);

endmodule

/* source/trigger_route.sv */
`timescale 1ns/1ps

module trigger_route (
	input  cw_route_pkg::trig_src_cfg_t trig_src_cfg_i,
	input  cw_route_pkg::trig_mod_cfg_t trig_mod_cfg_i,
	input  logic [5:0]                  trig_ext_in_i,   // bit 0 fa, bit 1 fb, then io1..io4
	input  cw_route_pkg::trig_mod_in_t  trig_mod_in_i,
	output logic                        trigger_ext_o,
	output logic [1:0]                  trigger_o
);
	import cw_route_pkg::*;

	logic ext_or;    // any enabled line high
	logic ext_and;   // all enabled lines high
	logic ext_comb;  // combined external trigger

	// module select shared by both capture outputs
	function automatic logic pick_module(
		input trig_module_e code,
		input logic         ext,    // value used for code 0
		input trig_mod_in_t mods
	);
		logic sel;
		case (code)
			MOD_EXT:        sel = ext;
			MOD_ADVIO:      sel = mods.advio;
			MOD_ANAPATTERN: sel = mods.anapattern;
			MOD_DECODEDIO:  sel = mods.decodedio;
			MOD_MMC:        sel = mods.mmc;
			MOD_EDGE:       sel = mods.edge_trig;
			default:        sel = 1'b0;   // codes 6 and 7
		endcase
		return sel;
	endfunction

	assign ext_or  = |(trig_ext_in_i & trig_src_cfg_i.enable);
	assign ext_and = &(trig_ext_in_i | ~trig_src_cfg_i.enable);   // disabled lines count as 1

	always_comb begin
		case (trig_src_cfg_i.mode)
			COMB_OR:   ext_comb = ext_or;
			COMB_AND:  ext_comb = ext_and;
			COMB_NAND: ext_comb = ~ext_and;
			default:   ext_comb = 1'b0;   // off
		endcase
	end

	assign trigger_ext_o = ext_comb;

	// primary code 0 routes the combined external trigger
	assign trigger_o[0] = pick_module(trig_mod_cfg_i.primary, ext_comb, trig_mod_in_i);

	// secondary code 0 disables the output
	assign trigger_o[1] = pick_module(trig_mod_cfg_i.secondary, 1'b0, trig_mod_in_i);

endmodule

/* source/target_power.sv */
`timescale 1ns/1ps

module target_power #(
	parameter int PWM_BITS   = 11,      // pwm period is 2**PWM_BITS cycles
	parameter int SOFT_STEPS = 16384,   // pwm periods spent in soft-start
	parameter int SOFT_DUTY  = 1400     // off time per pwm period
) (
	input  logic                     clk,
	input  logic                     reset,
	input  cw_route_pkg::power_cfg_t power_cfg_i,
	output logic                     targetpower_off_o,
	output logic                     io_highz_o
);
	import cw_route_pkg::*;

	localparam int STEP_W = (SOFT_STEPS > 1) ? $clog2(SOFT_STEPS) : 1;

	logic                off_q;         // registered power_off
	logic                off_falling;   // off_q about to drop
	logic                pwm_wrap;      // last cycle of a pwm period
	logic [PWM_BITS-1:0] pwm_cnt;       // free running
	logic [STEP_W-1:0]   step_cnt;      // soft-start periods done
	power_state_e        pwr_state;

	// off_q holds the previous value while the config bit moves,
	// so the FSM steps on the same edge that loads off_q
	assign off_falling = off_q && !power_cfg_i.power_off;
	assign pwm_wrap    = &pwm_cnt;

	always_ff @(posedge clk) begin
		if (reset) begin
			off_q   <= 1'b0;
			pwm_cnt <= '0;
		end else begin
			off_q   <= power_cfg_i.power_off;
			pwm_cnt <= pwm_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pwr_state <= PWR_ON;
			step_cnt  <= '0;
		end else if (power_cfg_i.power_off) begin
			pwr_state <= PWR_OFF;   // off wins over everything
			step_cnt  <= '0;
		end else if (off_falling) begin
			pwr_state <= power_cfg_i.fast_start ? PWR_ON : PWR_SOFT;
			step_cnt  <= '0;
		end else if (pwr_state == PWR_SOFT && pwm_wrap) begin
			if (step_cnt == STEP_W'(SOFT_STEPS - 1))
				pwr_state <= PWR_ON;   // ramp finished
			step_cnt <= step_cnt + 1'b1;
		end
	end

	always_comb begin
		case (pwr_state)
			PWR_OFF:  targetpower_off_o = 1'b1;
			PWR_SOFT: targetpower_off_o = (pwm_cnt < SOFT_DUTY);   // off for first part of period
			default:  targetpower_off_o = 1'b0;
		endcase
	end

	assign io_highz_o = off_q;   // release lines with the power switch

	a_state_legal: assert property (
		@(posedge clk) disable iff (reset)
		pwr_state inside {PWR_ON, PWR_OFF, PWR_SOFT}
	);

endmodule

/* source/target_io_route.sv */
`timescale 1ns/1ps

module target_io_route (
	input  logic                        io_highz_i,
	input  cw_route_pkg::io_route_cfg_t io_route_cfg_i,
	input  logic                        uart_tx_i,
	input  logic                        usi_out_i,
	input  logic [3:0]                  targetio_i,
	output logic [3:0]                  targetio_o,
	output logic [3:0]                  targetio_oe_o,
	output logic                        uart_rx_o,
	output logic                        usi_in_o
);
	import cw_route_pkg::*;

	logic [1:0] drv [4];   // {enable, value} per line before high-z override

	// drive priority for one line, result is {enable, value}
	function automatic logic [1:0] line_drive(
		input gpio_cfg_t cfg,
		input logic      usi_ok,   // line can carry usi out
		input logic      oc_ok,    // line has open-collector modes
		input logic      tx,
		input logic      usi
	);
		logic [1:0] r;
		r = 2'b00;
		if (cfg.tx)
			r = {1'b1, tx};
		else if (usi_ok && cfg.usio)
			r = {1'b1, usi};
		else if (oc_ok && cfg.usoc)
			r = {~usi, 1'b0};   // pull low only
		else if (oc_ok && cfg.txo)
			r = {~tx, 1'b0};    // pull low only
		else if (cfg.drive)
			r = {1'b1, cfg.level};
		return r;
	endfunction

	always_comb begin
		drv[0] = line_drive(io_route_cfg_i.gpio1, 1'b1, 1'b0, uart_tx_i, usi_out_i);
		drv[1] = line_drive(io_route_cfg_i.gpio2, 1'b1, 1'b0, uart_tx_i, usi_out_i);
		drv[2] = line_drive(io_route_cfg_i.gpio3, 1'b1, 1'b1, uart_tx_i, usi_out_i);
		drv[3] = line_drive(io_route_cfg_i.gpio4, 1'b0, 1'b0, uart_tx_i, usi_out_i);   // tx and drive only
		for (int i = 0; i < 4; i++) begin
			targetio_o[i]    = drv[i][0];
			targetio_oe_o[i] = drv[i][1] && !io_highz_i;   // power off floats every line
		end
	end

	// lowest numbered line wins, idle high when unassigned
	always_comb begin
		if (io_route_cfg_i.gpio1.rx)
			uart_rx_o = targetio_i[0];
		else if (io_route_cfg_i.gpio2.rx)
			uart_rx_o = targetio_i[1];
		else if (io_route_cfg_i.gpio3.rx)
			uart_rx_o = targetio_i[2];
		else if (io_route_cfg_i.gpio4.rx)
			uart_rx_o = targetio_i[3];
		else
			uart_rx_o = 1'b1;
	end

	always_comb begin
		if (io_route_cfg_i.gpio1.usii)
			usi_in_o = targetio_i[0];
		else if (io_route_cfg_i.gpio2.usii)
			usi_in_o = targetio_i[1];
		else if (io_route_cfg_i.gpio3.usii)
			usi_in_o = targetio_i[2];
		else
			usi_in_o = 1'b1;   // gpio4 has no usi input
	end

	a_highz_no_oe: assert final (!io_highz_i || (targetio_oe_o == 4'b0000));

endmodule

/* source/cw_route_top.sv */
`timescale 1ns/1ps

module cw_route_top #(
	parameter int PWM_BITS   = 11,
	parameter int SOFT_STEPS = 16384,
	parameter int SOFT_DUTY  = 1400
) (
	input  logic                       clk,
	input  logic                       reset,
	input  cw_route_pkg::reg_bus_t     reg_bus_i,
	input  cw_route_pkg::reg_addr_t    reg_hypaddr_i,
	output cw_route_pkg::hyplen_t      reg_hyplen_o,
	output cw_route_pkg::reg_byte_t    reg_rdata_o,
	input  logic [5:0]                 trig_ext_in_i,   // fa, fb, io1..io4 from bit 0
	input  cw_route_pkg::trig_mod_in_t trig_mod_in_i,
	output logic                       trigger_ext_o,
	output logic [1:0]                 trigger_o,       // to capture logic
	input  logic                       uart_tx_i,
	input  logic                       usi_out_i,
	input  logic [3:0]                 targetio_i,
	output logic [3:0]                 targetio_o,
	output logic [3:0]                 targetio_oe_o,
	output logic                       uart_rx_o,
	output logic                       usi_in_o,
	output logic                       targetpower_off_o,
	output logic                       avrprog_en_o,
	output cw_route_pkg::pin_ctl_t     pin_ctl_o
);
	import cw_route_pkg::*;

	trig_src_cfg_t trig_src;   // combine mode and enables
	trig_mod_cfg_t trig_mod;   // capture trigger selects
	io_route_cfg_t io_route;   // all eight routing bytes
	logic          io_highz;   // target unpowered

	cw_regfile cw_regfile_inst (
		.clk           (clk),
		.reset         (reset),
		.reg_bus_i     (reg_bus_i),
		.reg_hypaddr_i (reg_hypaddr_i),
		.reg_hyplen_o  (reg_hyplen_o),
		.reg_rdata_o   (reg_rdata_o),
		.trig_src_o    (trig_src),
		.trig_mod_o    (trig_mod),
		.io_route_o    (io_route)
	);

	trigger_route trigger_route_inst (
		.trig_src_cfg_i (trig_src),
		.trig_mod_cfg_i (trig_mod),
		.trig_ext_in_i  (trig_ext_in_i),
		.trig_mod_in_i  (trig_mod_in_i),
		.trigger_ext_o  (trigger_ext_o),
		.trigger_o      (trigger_o)
	);

	target_power #(
		.PWM_BITS   (PWM_BITS),
		.SOFT_STEPS (SOFT_STEPS),
		.SOFT_DUTY  (SOFT_DUTY)
	) target_power_inst (
		.clk               (clk),
		.reset             (reset),
		.power_cfg_i       (io_route.power),
		.targetpower_off_o (targetpower_off_o),
		.io_highz_o        (io_highz)
	);

	target_io_route target_io_route_inst (
		.io_highz_i     (io_highz),
		.io_route_cfg_i (io_route),
		.uart_tx_i      (uart_tx_i),
		.usi_out_i      (usi_out_i),
		.targetio_i     (targetio_i),
		.targetio_o     (targetio_o),
		.targetio_oe_o  (targetio_oe_o),
		.uart_rx_o      (uart_rx_o),
		.usi_in_o       (usi_in_o)
	);

	assign avrprog_en_o = io_route.power.avrprog;   // programming header connect
	assign pin_ctl_o    = io_route.pin_ctl;         // nrst, pdid, pdic static control

endmodule

/* testbench/tb_cw_route.sv */
`timescale 1ns/1ps

module tb_cw_route;
	import cw_route_pkg::*;

	localparam int PWM_BITS       = 4;
	localparam int SOFT_STEPS     = 4;
	localparam int SOFT_DUTY      = 10;
	localparam int TIMEOUT_CYCLES = 3000;   // tests need roughly 700 cycles
	localparam int SOFT_LIMIT     = (SOFT_STEPS + 1) * (2 ** PWM_BITS) + 2;

	logic         clk;
	logic         reset;
	reg_bus_t     reg_bus;
	reg_addr_t    hypaddr;
	hyplen_t      hyplen;
	reg_byte_t    rdata;
	logic [5:0]   trig_ext;      // fa, fb, io1..io4
	trig_mod_in_t trig_mod_in;
	logic         trigger_ext;
	logic [1:0]   trigger;
	logic         uart_tx;
	logic         usi_out;
	logic [3:0]   tio_in;
	logic [3:0]   tio_out;
	logic [3:0]   tio_oe;
	logic         uart_rx;
	logic         usi_in;
	logic         power_off;
	logic         avrprog_en;
	pin_ctl_t     pin_ctl;

	integer seed   = 89267;
	int     checks = 0;
	int     errors = 0;
	int     tests  = 0;
	int     cycles = 0;

	cw_route_top #(
		.PWM_BITS   (PWM_BITS),
		.SOFT_STEPS (SOFT_STEPS),
		.SOFT_DUTY  (SOFT_DUTY)
	) cw_route_top_inst (
		.clk               (clk),
		.reset             (reset),
		.reg_bus_i         (reg_bus),
		.reg_hypaddr_i     (hypaddr),
		.reg_hyplen_o      (hyplen),
		.reg_rdata_o       (rdata),
		.trig_ext_in_i     (trig_ext),
		.trig_mod_in_i     (trig_mod_in),
		.trigger_ext_o     (trigger_ext),
		.trigger_o         (trigger),
		.uart_tx_i         (uart_tx),
		.usi_out_i         (usi_out),
		.targetio_i        (tio_in),
		.targetio_o        (tio_out),
		.targetio_oe_o     (tio_oe),
		.uart_rx_o         (uart_rx),
		.usi_in_o          (usi_in),
		.targetpower_off_o (power_off),
		.avrprog_en_o      (avrprog_en),
		.pin_ctl_o         (pin_ctl)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;   // 8 ns period
	end

	initial begin
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: no result after %0d clock cycles", TIMEOUT_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests++;
		if (errors == err_start)
			$display("%s: done, no errors", name);
		else
			$display("%s: done, %0d errors", name, errors - err_start);
	endtask

	// register loads on the second edge, task returns right after it
	task automatic bus_write(input reg_addr_t addr, input int idx, input reg_byte_t data);
		@(posedge clk);
		reg_bus.addr    <= addr;
		reg_bus.bytecnt <= bytecnt_t'(idx);
		reg_bus.wdata   <= data;
		reg_bus.write   <= 1'b1;
		@(posedge clk);
		reg_bus <= '0;
	endtask

	task automatic bus_read(input reg_addr_t addr, input int idx, output reg_byte_t data);
		@(posedge clk);
		reg_bus.addr      <= addr;
		reg_bus.bytecnt   <= bytecnt_t'(idx);
		reg_bus.read      <= 1'b1;
		reg_bus.addrvalid <= 1'b1;
		@(posedge clk);   // byte captured, valid flag set
		reg_bus <= '0;
		@(negedge clk);
		data = rdata;
		@(negedge clk);
		check_value(rdata, 8'h00, "read data held longer than one cycle");
	endtask

	task automatic read_expect(input reg_addr_t addr, input int idx, input reg_byte_t exp,
		input string msg);
		reg_byte_t d;
		bus_read(addr, idx, d);
		check_value(d, exp, msg);
	endtask

	task automatic length_expect(input reg_addr_t addr, input int exp);
		@(posedge clk);
		hypaddr <= addr;
		@(negedge clk);
		check_value(hyplen, exp, $sformatf("length of address %0d", addr));
	endtask

	// combine rule: or of enabled, and with disabled lines as 1
	function automatic logic comb_expect(input logic [1:0] mode, input logic [5:0] en,
		input logic [5:0] lines);
		logic any_hi;
		logic all_hi;
		any_hi = 1'b0;
		all_hi = 1'b1;
		for (int i = 0; i < 6; i++) begin
			if (en[i] && lines[i])
				any_hi = 1'b1;
			if (en[i] && !lines[i])
				all_hi = 1'b0;
		end
		case (mode)
			2'd0:    return any_hi;
			2'd1:    return all_hi;
			2'd2:    return !all_hi;
			default: return 1'b0;   // off
		endcase
	endfunction

	// mods is {advio, anapattern, decodedio, mmc, edge}, code 1 picks the top bit
	function automatic logic module_expect(input logic [2:0] code, input logic ext,
		input logic [4:0] mods);
		if (code == 3'd0)
			return ext;
		if (code <= 3'd5)
			return mods[5 - code];
		return 1'b0;
	endfunction

	// {enable, value} for one target line from its routing byte
	function automatic logic [1:0] line_expect(input int line, input reg_byte_t cfg,
		input logic tx, input logic usi);
		if (cfg[0])
			return {1'b1, tx};
		if (cfg[2] && line < 3)
			return {1'b1, usi};
		if (line == 2 && cfg[4])
			return {!usi, 1'b0};   // usi open collector
		if (line == 2 && cfg[5])
			return {!tx, 1'b0};    // tx open collector
		if (cfg[7])
			return {1'b1, cfg[6]};
		return 2'b00;
	endfunction

	function automatic logic pick_lowest(input logic [3:0] sel, input logic [3:0] lines);
		for (int i = 0; i < 4; i++)
			if (sel[i])
				return lines[i];
		return 1'b1;   // idle high
	endfunction

	task automatic test_reset_state();
		int err_start;
		err_start = errors;
		@(negedge clk);
		check_value(power_off, 1'b0, "power off after reset");
		check_value(tio_oe, 4'b0001, "enables after reset");
		check_value(rdata, 8'h00, "read data after reset");
		check_value(trigger, 2'b00, "triggers after reset");
		read_expect(CW_TRIGSRC_ADDR, 0, 8'h01, "trigsrc reset value");
		read_expect(CW_TRIGMOD_ADDR, 0, 8'h00, "trigmod reset value");
		for (int i = 0; i < 8; i++)
			read_expect(CW_IOROUTE_ADDR, i, (i == 0) ? 8'h01 : (i == 1) ? 8'h02 : 8'h00,
				$sformatf("ioroute byte %0d reset value", i));
		length_expect(CW_TRIGSRC_ADDR, 1);
		length_expect(CW_TRIGMOD_ADDR, 1);
		length_expect(CW_IOROUTE_ADDR, 8);
		length_expect(6'd12, 0);   // unused
		finish_test("reset state and lengths", err_start);
	endtask

	task automatic test_write_readback();
		int        err_start;
		reg_byte_t src_v;
		reg_byte_t mod_v;
		reg_byte_t route_v [8];
		err_start = errors;
		src_v = reg_byte_t'($random(seed));
		mod_v = reg_byte_t'($random(seed));
		bus_write(CW_TRIGSRC_ADDR, 0, src_v);
		bus_write(CW_TRIGMOD_ADDR, 0, mod_v);
		for (int i = 0; i < 8; i++) begin
			route_v[i] = reg_byte_t'($random(seed));
			bus_write(CW_IOROUTE_ADDR, i, route_v[i]);
		end
		read_expect(CW_TRIGSRC_ADDR, 0, src_v, "trigsrc readback");
		read_expect(CW_TRIGMOD_ADDR, 0, mod_v, "trigmod readback");
		for (int i = 0; i < 8; i++)
			read_expect(CW_IOROUTE_ADDR, i, route_v[i], $sformatf("ioroute byte %0d readback", i));
		read_expect(6'd20, 0, 8'h00, "unknown address read");
		check_value(pin_ctl, route_v[6], "pin control byte");
		check_value(avrprog_en, route_v[5][0], "avr programming enable");
		finish_test("write and readback", err_start);
	endtask

	task automatic test_trigger();
		int         err_start;
		logic [1:0] mode;
		logic [5:0] en;
		logic [2:0] code;
		logic       exp_ext;
		err_start = errors;
		bus_write(CW_TRIGMOD_ADDR, 0, 8'h00);   // primary ext, secondary off
		for (int m = 0; m < 4; m++) begin
			mode = 2'(m);
			en   = 6'($random(seed));
			bus_write(CW_TRIGSRC_ADDR, 0, {mode, en});
			for (int k = 0; k < 12; k++) begin
				@(posedge clk);
				trig_ext    <= 6'($random(seed));
				trig_mod_in <= trig_mod_in_t'(5'($random(seed)));
				@(negedge clk);
				exp_ext = comb_expect(mode, en, trig_ext);
				check_value(trigger_ext, exp_ext, $sformatf("combined trigger, mode %0d", m));
				check_value(trigger[0], exp_ext, $sformatf("trigger 0 from ext, mode %0d", m));
				check_value(trigger[1], 1'b0, "trigger 1 disabled");
			end
		end
		bus_write(CW_TRIGSRC_ADDR, 0, 8'h3f);   // or of all six lines
		for (int c = 0; c < 8; c++) begin
			code = 3'(c);
			bus_write(CW_TRIGMOD_ADDR, 0, {code, 2'b00, code});
			for (int k = 0; k < 6; k++) begin
				@(posedge clk);
				trig_ext    <= 6'($random(seed));
				trig_mod_in <= trig_mod_in_t'(5'($random(seed)));
				@(negedge clk);
				exp_ext = comb_expect(2'd0, 6'h3f, trig_ext);
				check_value(trigger[0], module_expect(code, exp_ext, trig_mod_in),
					$sformatf("trigger 0 with code %0d", c));
				check_value(trigger[1], module_expect(code, 1'b0, trig_mod_in),
					$sformatf("trigger 1 with code %0d", c));
			end
		end
		finish_test("trigger logic", err_start);
	endtask

	task automatic route_case(input reg_byte_t g1, input reg_byte_t g2, input reg_byte_t g3,
		input reg_byte_t g4, input string name);
		reg_byte_t  cfg [4];
		logic [1:0] exp_line;
		logic [3:0] exp_oe;
		logic [3:0] exp_o;
		logic [3:0] rx_sel;
		logic [3:0] usi_sel;
		logic [2:0] pat;
		cfg[0] = g1;
		cfg[1] = g2;
		cfg[2] = g3;
		cfg[3] = g4;
		for (int i = 0; i < 4; i++) begin
			bus_write(CW_IOROUTE_ADDR, i, cfg[i]);
			rx_sel[i]  = cfg[i][1];
			usi_sel[i] = cfg[i][3] && (i < 3);   // no usi input on gpio4
		end
		for (int k = 0; k < 8; k++) begin
			pat = 3'(k);
			@(posedge clk);
			uart_tx <= pat[0];
			usi_out <= pat[1];
			tio_in  <= 4'($random(seed));
			@(negedge clk);
			for (int i = 0; i < 4; i++) begin
				exp_line  = line_expect(i, cfg[i], uart_tx, usi_out);
				exp_oe[i] = exp_line[1];
				exp_o[i]  = exp_line[0];
			end
			check_value(tio_oe, exp_oe, {name, ", enables"});
			check_value(tio_out & exp_oe, exp_o & exp_oe, {name, ", driven levels"});
			check_value(uart_rx, pick_lowest(rx_sel, tio_in), {name, ", uart rx"});
			check_value(usi_in, pick_lowest(usi_sel, tio_in), {name, ", usi in"});
		end
	endtask

	task automatic test_io_routing();
		int err_start;
		err_start = errors;
		bus_write(CW_IOROUTE_ADDR, 5, 8'h04);   // power on, fast start
		route_case(8'h01, 8'h02, 8'h00, 8'h00, "reset routing");
		route_case(8'h00, 8'h04, 8'h80, 8'hc1, "usio and static levels");
		route_case(8'h04, 8'h00, 8'h10, 8'hc0, "usi open collector");
		route_case(8'h00, 8'h00, 8'h20, 8'h40, "tx open collector");
		route_case(8'h00, 8'h0a, 8'h0e, 8'h02, "rx and usii priority");
		route_case(8'h00, 8'h00, 8'h14, 8'h06, "usio over open collector");
		route_case(8'h00, 8'h00, 8'h00, 8'h00, "nothing routed");
		route_case(8'h89, 8'h00, 8'h00, 8'h08, "tx over drive");
		finish_test("io routing", err_start);
	endtask

	task automatic test_fast_power();
		int err_start;
		err_start = errors;
		bus_write(CW_IOROUTE_ADDR, 0, 8'h01);   // gpio1 tx
		bus_write(CW_IOROUTE_ADDR, 1, 8'h00);
		bus_write(CW_IOROUTE_ADDR, 2, 8'h00);
		bus_write(CW_IOROUTE_ADDR, 3, 8'h80);   // gpio4 driven low
		bus_write(CW_IOROUTE_ADDR, 5, 8'h04);
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value({power_off, tio_oe}, 5'b01001, "powered before switch off");
		bus_write(CW_IOROUTE_ADDR, 5, 8'h06);   // power off, fast
		@(negedge clk);
		check_value({power_off, tio_oe}, 5'b01001, "power off applied too early");
		@(negedge clk);
		check_value({power_off, tio_oe}, 5'b10000, "power off one cycle after write");
		bus_write(CW_IOROUTE_ADDR, 5, 8'h04);
		@(negedge clk);
		check_value({power_off, tio_oe}, 5'b10000, "power on applied too early");
		@(negedge clk);
		check_value({power_off, tio_oe}, 5'b01001, "power on one cycle after write");
		finish_test("fast power switching", err_start);
	endtask

	task automatic test_slow_power();
		int err_start;
		int first_low;
		int last_high;
		err_start = errors;
		bus_write(CW_IOROUTE_ADDR, 5, 8'h02);   // power off, slow start
		repeat (2) @(negedge clk);
		check_value(power_off, 1'b1, "power off before soft start");
		bus_write(CW_IOROUTE_ADDR, 5, 8'h00);
		first_low = -1;
		last_high = -1;
		for (int n = 1; n <= SOFT_LIMIT + 32; n++) begin
			@(negedge clk);
			if (power_off)
				last_high = n;
			else if (first_low < 0)
				first_low = n;
		end
		check_value(first_low > 0 && last_high > first_low, 1'b1, "soft start never toggled");
		check_value(last_high < SOFT_LIMIT, 1'b1, "soft start not done within limit");
		check_value(power_off, 1'b0, "power on after soft start");
		finish_test("slow power switching", err_start);
	endtask

	initial begin
		reset       = 1'b1;
		reg_bus     = '0;
		hypaddr     = '0;
		trig_ext    = '0;
		trig_mod_in = '0;
		uart_tx     = 1'b1;   // uart idle
		usi_out     = 1'b1;
		tio_in      = '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_write_readback();
		test_trigger();
		test_io_routing();
		test_fast_power();
		test_slow_power();
		$display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* flist.f */
source/cw_route_pkg.sv
source/cw_regfile.sv
source/trigger_route.sv
source/target_power.sv
source/target_io_route.sv
source/cw_route_top.sv
testbench/tb_cw_route.sv
